//--- verilog/cpu_defines.svh
// cpu_defines
// Architectural widths, pipeline stage count and the fixed
// fetch vectors shared by the front-end control core.

`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and address width
`define XLEN            32

// PREIF, IF, ID, EXE, MEM, MEM2, WB
`define NUM_STAGES      7

// boot ROM entry after reset
`define RESET_VECTOR    32'hBFC0_0000

// general exception entry, BEV=1 space
`define EXC_VECTOR      32'hBFC0_0380

// j/jal instruction index field
`define INSTR_INDEX_W   26

`endif

//--- verilog/cpu_pkg.sv
// cpu_pkg
// Enumerated types for the front-end control core: pipeline stage
// index, exception entry request, branch kind and next-PC source.

package cpu_pkg;

    typedef enum logic [2:0] {
        STG_PREIF = 3'd0,
        STG_IF    = 3'd1,
        STG_ID    = 3'd2,
        STG_EXE   = 3'd3,
        STG_MEM   = 3'd4,
        STG_MEM2  = 3'd5,
        STG_WB    = 3'd6
    } stage_e;

    typedef enum logic [1:0] {
        ENTRY_NONE = 2'd0,
        ENTRY_EXC  = 2'd1,      // take exception
        ENTRY_ERET = 2'd2       // return to epc
    } entry_sel_e;

    typedef enum logic {
        BR_COND = 1'b0,         // pc-relative
        BR_JR   = 1'b1          // register target
    } branch_type_e;

    typedef enum logic [2:0] {
        NPC_SEQ    = 3'd0,
        NPC_BRANCH = 3'd1,
        NPC_JR     = 3'd2,
        NPC_JUMP   = 3'd3,
        NPC_EXC    = 3'd4,
        NPC_ERET   = 3'd5
    } npc_sel_e;

endpackage

//--- verilog/pipe_control.sv
// pipe_control
// Resolves exception, stall and redirect causes by fixed priority into
// per-stage write enables, per-stage flushes and the next-PC source.
// Purely combinational.

`timescale 1ns/10ps
`include "cpu_defines.svh"

module pipe_control (
    input  cpu_pkg::entry_sel_e    entry_sel,
    input  logic                   dcache_busy,
    input  logic                   muldiv_busy,
    input  logic                   dh_stall,
    input  logic                   branch_failed,
    input  cpu_pkg::branch_type_e  exe_branch_type,
    input  logic                   imme_jump,
    input  logic                   icache_busy,
    output logic [`NUM_STAGES-1:0] stage_wr,
    output logic [`NUM_STAGES-1:0] stage_flush,
    output cpu_pkg::npc_sel_e      npc_sel
);

    always_comb begin
        stage_wr    = '1;                   // free running by default
        stage_flush = '0;
        npc_sel     = cpu_pkg::NPC_SEQ;

        if (entry_sel != cpu_pkg::ENTRY_NONE) begin
            // everything younger than WB is killed
            stage_flush[cpu_pkg::STG_IF]   = 1'b1;
            stage_flush[cpu_pkg::STG_ID]   = 1'b1;
            stage_flush[cpu_pkg::STG_EXE]  = 1'b1;
            stage_flush[cpu_pkg::STG_MEM]  = 1'b1;
            stage_flush[cpu_pkg::STG_MEM2] = 1'b1;
            if (entry_sel == cpu_pkg::ENTRY_ERET) begin
                npc_sel = cpu_pkg::NPC_ERET;
            end else begin
                npc_sel = cpu_pkg::NPC_EXC;
            end
        end else if (dcache_busy) begin
            stage_wr = '0;                  // whole pipe frozen
        end else if (muldiv_busy) begin
            stage_wr[cpu_pkg::STG_PREIF] = 1'b0;
            stage_wr[cpu_pkg::STG_IF]    = 1'b0;
            stage_wr[cpu_pkg::STG_ID]    = 1'b0;
            stage_wr[cpu_pkg::STG_EXE]   = 1'b0;
            stage_flush[cpu_pkg::STG_MEM] = 1'b1;   // bubble behind mul/div
        end else if (dh_stall) begin
            stage_wr[cpu_pkg::STG_PREIF] = 1'b0;
            stage_wr[cpu_pkg::STG_IF]    = 1'b0;
            stage_wr[cpu_pkg::STG_ID]    = 1'b0;
            stage_flush[cpu_pkg::STG_EXE] = 1'b1;   // bubble into exe
        end else if (branch_failed) begin
            // wrong-path instrs in IF and ID
            stage_flush[cpu_pkg::STG_IF] = 1'b1;
            stage_flush[cpu_pkg::STG_ID] = 1'b1;
            if (exe_branch_type == cpu_pkg::BR_JR) begin
                npc_sel = cpu_pkg::NPC_JR;
            end else begin
                npc_sel = cpu_pkg::NPC_BRANCH;
            end
        end else if (imme_jump) begin
            stage_flush[cpu_pkg::STG_IF] = 1'b1;    // only the fetch slot is wrong
            npc_sel = cpu_pkg::NPC_JUMP;
        end else if (icache_busy) begin
            stage_wr[cpu_pkg::STG_PREIF] = 1'b0;
            stage_wr[cpu_pkg::STG_IF]    = 1'b0;
            stage_flush[cpu_pkg::STG_ID] = 1'b1;    // no valid instr for ID yet
        end
    end

endmodule

//--- verilog/pc_gen.sv
// pc_gen
// Pre-fetch program counter. Computes the sequential, branch, register
// and immediate jump targets, selects one by npc_sel and loads it when
// PREIF writes. Flags a misaligned fetch address.

`timescale 1ns/10ps
`include "cpu_defines.svh"

module pc_gen (
    input  logic               aclk,
    input  logic               rst_n,
    input  logic               pc_wr,
    input  cpu_pkg::npc_sel_e  npc_sel,
    input  logic [`XLEN-1:0]   epc,
    input  logic [`XLEN-1:0]   exe_pc,
    input  logic [`XLEN-1:0]   exe_imm32,
    input  logic [`XLEN-1:0]   exe_busa,
    input  logic [`XLEN-1:0]   id_pc,
    input  logic [`XLEN-1:0]   id_instr,
    output logic [`XLEN-1:0]   pc,
    output logic               fetch_adel
);

    logic [`XLEN-1:0] seq_target;
    logic [`XLEN-1:0] branch_target;
    logic [`XLEN-1:0] jr_target;
    logic [`XLEN-1:0] jump_target;
    logic [`XLEN-1:0] exe_pc_plus4;
    logic [`XLEN-1:0] id_pc_plus4;
    logic [`XLEN-1:0] branch_offset;
    logic [`XLEN-1:0] next_pc;

    assign seq_target = pc + `XLEN'd4;

    // branch is relative to the delay slot address
    assign exe_pc_plus4  = exe_pc + `XLEN'd4;
    assign branch_offset = {exe_imm32[`XLEN-3:0], 2'b00};   // word offset
    assign branch_target = exe_pc_plus4 + branch_offset;

    assign jr_target = exe_busa;

    // j/jal stays inside the 256 MB region of the delay slot
    assign id_pc_plus4 = id_pc + `XLEN'd4;
    assign jump_target = {id_pc_plus4[`XLEN-1 -: 4],
                          id_instr[`INSTR_INDEX_W-1:0],
                          2'b00};

    always_comb begin
        case (npc_sel)
            cpu_pkg::NPC_SEQ:    next_pc = seq_target;
            cpu_pkg::NPC_BRANCH: next_pc = branch_target;
            cpu_pkg::NPC_JR:     next_pc = jr_target;
            cpu_pkg::NPC_JUMP:   next_pc = jump_target;
            cpu_pkg::NPC_EXC:    next_pc = `EXC_VECTOR;
            cpu_pkg::NPC_ERET:   next_pc = epc;
            default:             next_pc = seq_target;     // unused codes
        endcase
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_VECTOR;
        end else if (pc_wr) begin
            pc <= next_pc;          // hold while PREIF stalls
        end
    end

    // AdEL on fetch, recorded by IF with the instruction
    assign fetch_adel = |pc[1:0];

endmodule

//--- verilog/fetch_ctrl_top.sv
// fetch_ctrl_top
// Front-end control core: pipeline write-enable and flush control
// together with the pre-fetch PC generator.

`timescale 1ns/10ps
`include "cpu_defines.svh"

module fetch_ctrl_top (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  cpu_pkg::entry_sel_e    entry_sel,
    input  logic [`XLEN-1:0]       epc,
    input  logic                   dcache_busy,
    input  logic                   icache_busy,
    input  logic                   muldiv_busy,
    input  logic                   dh_stall,
    input  logic                   branch_failed,
    input  cpu_pkg::branch_type_e  exe_branch_type,
    input  logic [`XLEN-1:0]       exe_pc,
    input  logic [`XLEN-1:0]       exe_imm32,
    input  logic [`XLEN-1:0]       exe_busa,
    input  logic                   imme_jump,
    input  logic [`XLEN-1:0]       id_pc,
    input  logic [`XLEN-1:0]       id_instr,
    output logic [`NUM_STAGES-1:0] stage_wr,
    output logic [`NUM_STAGES-1:0] stage_flush,
    output logic [`XLEN-1:0]       pc,
    output logic                   fetch_adel
);

    cpu_pkg::npc_sel_e npc_sel;     // winning redirect source

    pipe_control u_pipe_control (
        .entry_sel       (entry_sel),
        .dcache_busy     (dcache_busy),
        .muldiv_busy     (muldiv_busy),
        .dh_stall        (dh_stall),
        .branch_failed   (branch_failed),
        .exe_branch_type (exe_branch_type),
        .imme_jump       (imme_jump),
        .icache_busy     (icache_busy),
        .stage_wr        (stage_wr),
        .stage_flush     (stage_flush),
        .npc_sel         (npc_sel)
    );

    pc_gen u_pc_gen (
        .aclk            (aclk),
        .rst_n           (rst_n),
        .pc_wr           (stage_wr[cpu_pkg::STG_PREIF]),   // PREIF enable
        .npc_sel         (npc_sel),
        .epc             (epc),
        .exe_pc          (exe_pc),
        .exe_imm32       (exe_imm32),
        .exe_busa        (exe_busa),
        .id_pc           (id_pc),
        .id_instr        (id_instr),
        .pc              (pc),
        .fetch_adel      (fetch_adel)
    );

endmodule

//--- dv/fetch_ctrl_assert.sv
// fetch_ctrl_assert
// Concurrent checks on the stage enables, flushes and pc hold,
// bound to the front-end control top level.

`timescale 1ns/10ps
`include "cpu_defines.svh"

module fetch_ctrl_assert (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  cpu_pkg::entry_sel_e    entry_sel,
    input  logic                   dcache_busy,
    input  logic [`NUM_STAGES-1:0] stage_wr,
    input  logic [`NUM_STAGES-1:0] stage_flush,
    input  logic [`XLEN-1:0]       pc
);

    exc_all_write: assert property (@(posedge aclk) disable iff (!rst_n)
        (entry_sel != cpu_pkg::ENTRY_NONE) |-> (&stage_wr))
        else $error("exception entry with a stage not writing");

    dcache_freeze: assert property (@(posedge aclk) disable iff (!rst_n)
        (entry_sel == cpu_pkg::ENTRY_NONE && dcache_busy) |-> (stage_wr == '0))
        else $error("stage writing during a data-cache stall");

    flush_not_held: assert property (@(posedge aclk) disable iff (!rst_n)
        ((stage_flush & ~stage_wr) == '0))
        else $error("flushed stage is also held");

    // pc frozen while PREIF holds
    pc_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        !stage_wr[cpu_pkg::STG_PREIF] |=> $stable(pc))
        else $error("pc moved after a PREIF hold");

endmodule

bind fetch_ctrl_top fetch_ctrl_assert u_fetch_ctrl_assert (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .entry_sel   (entry_sel),
    .dcache_busy (dcache_busy),
    .stage_wr    (stage_wr),
    .stage_flush (stage_flush),
    .pc          (pc)
);

//--- dv/fetch_ctrl_tb.sv
// fetch_ctrl_tb
// Testbench for the front-end control core. Replays per-cycle stimulus
// and expected outputs from the golden file, checks the stage enables,
// flushes, pc and fetch_adel, and prints one closing report.

`timescale 1ns/10ps
`include "cpu_defines.svh"

module fetch_ctrl_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int REC_WORDS    = 11;      // words per golden line
    localparam int MAX_RECORDS  = 64;

    logic                   aclk;
    logic                   rst_n;
    cpu_pkg::entry_sel_e    entry_sel;
    logic [`XLEN-1:0]       epc;
    logic                   dcache_busy;
    logic                   icache_busy;
    logic                   muldiv_busy;
    logic                   dh_stall;
    logic                   branch_failed;
    cpu_pkg::branch_type_e  exe_branch_type;
    logic [`XLEN-1:0]       exe_pc;
    logic [`XLEN-1:0]       exe_imm32;
    logic [`XLEN-1:0]       exe_busa;
    logic                   imme_jump;
    logic [`XLEN-1:0]       id_pc;
    logic [`XLEN-1:0]       id_instr;
    logic [`NUM_STAGES-1:0] stage_wr;
    logic [`NUM_STAGES-1:0] stage_flush;
    logic [`XLEN-1:0]       pc;
    logic                   fetch_adel;

    logic [31:0] golden_mem [0:REC_WORDS*MAX_RECORDS-1];
    int          num_records;
    int          error_count;
    int          cycle_idx;
    logic        load_done;

    fetch_ctrl_top i_fetch_ctrl_top (
        .aclk            (aclk),
        .rst_n           (rst_n),
        .entry_sel       (entry_sel),
        .epc             (epc),
        .dcache_busy     (dcache_busy),
        .icache_busy     (icache_busy),
        .muldiv_busy     (muldiv_busy),
        .dh_stall        (dh_stall),
        .branch_failed   (branch_failed),
        .exe_branch_type (exe_branch_type),
        .exe_pc          (exe_pc),
        .exe_imm32       (exe_imm32),
        .exe_busa        (exe_busa),
        .imme_jump       (imme_jump),
        .id_pc           (id_pc),
        .id_instr        (id_instr),
        .stage_wr        (stage_wr),
        .stage_flush     (stage_flush),
        .pc              (pc),
        .fetch_adel      (fetch_adel)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD/2) aclk = ~aclk;
    end

    task automatic clear_inputs();
        entry_sel       = cpu_pkg::ENTRY_NONE;
        epc             = '0;
        dcache_busy     = 1'b0;
        icache_busy     = 1'b0;
        muldiv_busy     = 1'b0;
        dh_stall        = 1'b0;
        branch_failed   = 1'b0;
        exe_branch_type = cpu_pkg::BR_COND;
        exe_pc          = '0;
        exe_imm32       = '0;
        exe_busa        = '0;
        imme_jump       = 1'b0;
        id_pc           = '0;
        id_instr        = '0;
    endtask

    // ctrl word bit map follows the golden file header
    task automatic apply_record(input int idx);
        int          base;
        logic [31:0] ctrl;
        base            = idx * REC_WORDS;
        ctrl            = golden_mem[base];
        entry_sel       = cpu_pkg::entry_sel_e'(ctrl[1:0]);
        dcache_busy     = ctrl[2];
        muldiv_busy     = ctrl[3];
        dh_stall        = ctrl[4];
        branch_failed   = ctrl[5];
        exe_branch_type = cpu_pkg::branch_type_e'(ctrl[6]);
        imme_jump       = ctrl[7];
        icache_busy     = ctrl[8];
        epc             = golden_mem[base+1];
        exe_pc          = golden_mem[base+2];
        exe_imm32       = golden_mem[base+3];
        exe_busa        = golden_mem[base+4];
        id_pc           = golden_mem[base+5];
        id_instr        = golden_mem[base+6];
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s at record %0d: got %h, expected %h",
                     name, cycle_idx, actual, expected);
            error_count++;
        end
    endtask

    task automatic compare_outputs(input int idx);
        int base;
        base = idx * REC_WORDS;
        check_value("stage_wr", {{(32-`NUM_STAGES){1'b0}}, stage_wr}, golden_mem[base+7]);
        check_value("stage_flush", {{(32-`NUM_STAGES){1'b0}}, stage_flush},
                    golden_mem[base+8]);
        check_value("pc", pc, golden_mem[base+9]);
        check_value("fetch_adel", {31'd0, fetch_adel}, golden_mem[base+10]);
    endtask

    initial begin
        error_count = 0;
        num_records = 0;
        cycle_idx   = 0;
        load_done   = 1'b0;
        rst_n       = 1'b0;
        clear_inputs();
        for (int i = 0; i < REC_WORDS*MAX_RECORDS; i++) begin
            golden_mem[i] = 32'hFFFF_0000 | i;     // marks unused slots
        end
        $readmemh("dv/fetch_ctrl_golden.txt", golden_mem);
        while (num_records < MAX_RECORDS &&
               golden_mem[num_records*REC_WORDS][31:16] != 16'hFFFF) begin
            num_records++;
        end
        load_done = 1'b1;
        if (num_records == 0) begin
            $display("error: no stimulus records found in the golden file");
            error_count++;
        end

        repeat (RESET_CYCLES) @(posedge aclk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < num_records; i++) begin
            if (i > 0) begin
                @(posedge aclk);
                #1;
            end
            cycle_idx = i;
            apply_record(i);
            #2;                                 // 1 ns before the next edge
            compare_outputs(i);
        end

        $display("errors: %0d in %0d records", error_count, num_records);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog sized from the record count
    initial begin
        wait (load_done);
        #(num_records * CLK_PERIOD + 100);
        $display("error: timeout, the run did not finish within the expected time");
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- dv/fetch_ctrl_golden.txt
// ctrl epc exe_pc exe_imm32 exe_busa id_pc id_instr | exp stage_wr stage_flush pc fetch_adel
// ctrl bits: 1:0 entry_sel, 2 dcache, 3 muldiv, 4 dh, 5 br_failed, 6 br_jr, 7 j, 8 icache
// reset then sequential fetch
000 00000000 00000000 00000000 00000000 00000000 00000000 7f 00 bfc00000 0
000 00000000 00000000 00000000 00000000 00000000 00000000 7f 00 bfc00004 0
000 00000000 00000000 00000000 00000000 00000000 00000000 7f 00 bfc00008 0
// single stall causes
004 00000000 00000000 00000000 00000000 00000000 00000000 00 00 bfc0000c 0
004 00000000 00000000 00000000 00000000 00000000 00000000 00 00 bfc0000c 0
008 00000000 00000000 00000000 00000000 00000000 00000000 70 10 bfc0000c 0
010 00000000 00000000 00000000 00000000 00000000 00000000 78 08 bfc0000c 0
100 00000000 00000000 00000000 00000000 00000000 00000000 7c 04 bfc0000c 0
000 00000000 00000000 00000000 00000000 00000000 00000000 7f 00 bfc0000c 0
// redirects
020 00000000 bfc00008 00000010 00000000 00000000 00000000 7f 06 bfc00010 0
000 00000000 00000000 00000000 00000000 00000000 00000000 7f 00 bfc0004c 0
020 00000000 bfc00048 fffffff8 00000000 00000000 00000000 7f 06 bfc00050 0
060 00000000 00000000 00000000 80001230 00000000 00000000 7f 06 bfc0002c 0
080 00000000 00000000 00000000 00000000 8000122c 0c012345 7f 02 80001230 0
001 00000000 00000000 00000000 00000000 00000000 00000000 7f 3e 80048d14 0
000 00000000 00000000 00000000 00000000 00000000 00000000 7f 00 bfc00380 0
002 80048d18 00000000 00000000 00000000 00000000 00000000 7f 3e bfc00384 0
000 00000000 00000000 00000000 00000000 00000000 00000000 7f 00 80048d18 0
// causes raised together
005 12345678 00000000 00000000 00000000 00000000 00000000 7f 3e 80048d1c 0
030 00000000 80000000 00000100 00000000 00000000 00000000 78 08 bfc00380 0
120 00000000 bfc00380 00000004 00000000 00000000 00000000 7f 06 bfc00380 0
098 00000000 00000000 00000000 00000000 bfc00390 08000040 70 10 bfc00394 0
180 00000000 00000000 00000000 00000000 bfc00390 08000040 7f 02 bfc00394 0
02c 00000000 80000000 00000020 00000000 00000000 00000000 00 00 b0000100 0
// misaligned fetch address
060 00000000 00000000 00000000 80000102 00000000 00000000 7f 06 b0000100 0
000 00000000 00000000 00000000 00000000 00000000 00000000 7f 00 80000102 1
100 00000000 00000000 00000000 00000000 00000000 00000000 7c 04 80000106 1
000 00000000 00000000 00000000 00000000 00000000 00000000 7f 00 80000106 1
020 00000000 80000100 00000003 00000000 00000000 00000000 7f 06 8000010a 1
000 00000000 00000000 00000000 00000000 00000000 00000000 7f 00 80000110 0
060 00000000 00000000 00000000 80000201 00000000 00000000 7f 06 80000114 0
002 80000400 00000000 00000000 00000000 00000000 00000000 7f 3e 80000201 1
000 00000000 00000000 00000000 00000000 00000000 00000000 7f 00 80000400 0
000 00000000 00000000 00000000 00000000 00000000 00000000 7f 00 80000404 0

//--- fetch_ctrl.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/pipe_control.sv
verilog/pc_gen.sv
verilog/fetch_ctrl_top.sv
dv/fetch_ctrl_assert.sv
dv/fetch_ctrl_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       = fetch_ctrl_tb
FILELIST  = fetch_ctrl.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
